// ==== bench/tb_cdr_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cdr_top;
    import cdr_pack::*;

    localparam int gain_width      = 4;
    localparam int phase_est_shift = 12;
    localparam int acc_w           = Nadc + 2 + phase_est_shift;

    // timeout is twice the summed test lengths in cycles
    localparam int reset_cycles  = 16;
    localparam int wait_cycles   = 40;
    localparam int prop_cycles   = 300;
    localparam int freq_cycles   = 150;
    localparam int ramp_cycles   = 400;
    localparam int ovr_cycles    = 40;
    localparam int misc_cycles   = 100;
    localparam int timeout_limit = 2 * (reset_cycles + wait_cycles + 2 * prop_cycles
        + 2 * freq_cycles + ramp_cycles + 2 * ovr_cycles + misc_cycles);

    // snapshot sampler states of the model
    localparam int s_wait   = 0;
    localparam int s_ready  = 1;
    localparam int s_sample = 2;

    typedef logic signed [acc_w-1:0] acc_t;

    logic        clk;
    logic        ext_rstb;
    adc_sample_t din [Nti-1:0];
    logic        ramp_clock;
    logic        wr_en;
    cfg_addr_t   addr;
    cfg_data_t   wdata;
    cfg_data_t   rdata;
    pi_code_t    pi_ctl [Nout-1:0];
    logic        freq_lvl_cross;
    logic        wait_on_reset_b;

    int          err_count;
    int          pass_count;
    int          cycle_count;
    int unsigned seed_val;

    // reference loop state
    acc_t       m_phase;
    acc_t       m_freq;
    acc_t       m_prev_fu;
    acc_t       m_rp;
    acc_t       m_rn;
    logic       m_rc_ff;
    logic       m_rc_sync;
    logic       m_lvl;
    int         m_edges;
    int         m_state;
    pd_err_t    m_snap_phase;
    acc_t       m_snap_freq;
    acc_t       m_snap_ramp;
    logic [4:0] m_ctrl;
    logic [3:0] m_kp;
    logic [3:0] m_ki;
    logic [3:0] m_kr;
    pd_err_t    m_offset;
    pi_code_t   m_ext;

    cdr_top #(
        .gain_width      (gain_width),
        .phase_est_shift (phase_est_shift)
    ) dut (
        .clk               (clk),
        .ext_rstb          (ext_rstb),
        .din_i             (din),
        .ramp_clock_i      (ramp_clock),
        .wr_en_i           (wr_en),
        .addr_i            (addr),
        .wdata_i           (wdata),
        .rdata_o           (rdata),
        .pi_ctl_o          (pi_ctl),
        .freq_lvl_cross_o  (freq_lvl_cross),
        .wait_on_reset_b_o (wait_on_reset_b)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // clamped mueller-muller error over adjacent lanes plus offset
    function automatic pd_err_t pd_model(input pd_err_t offset);
        int sum;
        int sa;
        int sb;
        sum = int'(offset);
        for (int k = 1; k < Nti; k++) begin
            sa = din[k-1][Nadc-1] ? -1 : 1;
            sb = din[k][Nadc-1] ? -1 : 1;
            sum = sum + sa * int'(din[k]) - sb * int'(din[k-1]);
        end
        if (sum > 2 ** (Nadc + 1) - 1) begin
            sum = 2 ** (Nadc + 1) - 1;
        end else if (sum < -(2 ** (Nadc + 1))) begin
            sum = -(2 ** (Nadc + 1));
        end
        return pd_err_t'(sum);
    endfunction

    function automatic pi_code_t pi_model();
        acc_t sh;
        sh = m_phase >>> phase_est_shift;
        return m_ctrl[3] ? m_ext : sh[Npi-1:0];
    endfunction

    // readback word the snapshot registers should give
    function automatic cfg_data_t snap_word(input cfg_addr_t a);
        int ph;
        int fr;
        int rp;
        ph = int'(m_snap_phase);
        fr = int'(m_snap_freq);
        rp = int'(m_snap_ramp);
        case (a)
            4'd4: return ph[15:0];
            4'd5: return fr[15:0];
            4'd6: return fr[31:16];
            4'd7: return rp[15:0];
            4'd8: return rp[31:16];
            default: return 16'h0000;
        endcase
    endfunction

    // model steps on the same edge as the DUT and from the same inputs
    always @(posedge clk or negedge ext_rstb) begin
        pd_err_t pe;
        pd_err_t e;
        acc_t    ew;
        acc_t    rp_upd;
        acc_t    rn_upd;
        acc_t    fu;
        acc_t    ph_int;
        if (!ext_rstb) begin
            m_phase      = '0;
            m_freq       = '0;
            m_prev_fu    = '0;
            m_rp         = '0;
            m_rn         = '0;
            m_rc_ff      = 1'b0;
            m_rc_sync    = 1'b0;
            m_lvl        = 1'b0;
            m_edges      = 0;
            m_state      = s_wait;
            m_snap_phase = '0;
            m_snap_freq  = '0;
            m_snap_ramp  = '0;
            m_ctrl       = '0;
            m_kp         = '0;
            m_ki         = '0;
            m_kr         = '0;
            m_offset     = '0;
            m_ext        = '0;
        end else begin
            pe = pd_model(m_offset);
            e = m_ctrl[0] ? -pe : pe;
            // error held at zero for the first 32 edges so all state stays zero
            if (m_edges < 32) begin
                e = '0;
            end
            ew = acc_t'(e);
            rp_upd = ramp_clock ? m_rp + (ew << m_kr) : m_rp;
            rn_upd = ramp_clock ? m_rn : m_rn + (ew << m_kr);
            fu = (ew << m_ki) + (m_rc_sync ? m_rp : -m_rn);
            m_lvl = fu > m_prev_fu;
            ph_int = m_phase >>> phase_est_shift;
            case (m_state)
                s_wait: m_state = m_ctrl[4] ? s_wait : s_ready;
                s_ready: m_state = m_ctrl[4] ? s_sample : s_ready;
                default: begin
                    m_snap_phase = ph_int[Nadc+1:0];
                    m_snap_freq  = fu;
                    m_snap_ramp  = ramp_clock ? rp_upd : rn_upd;
                    m_state      = s_wait;
                end
            endcase
            m_phase = m_phase + (ew << m_kp) + m_freq;
            if (m_ctrl[1]) begin
                m_freq = m_freq + fu;
            end
            m_rp = m_ctrl[2] ? rp_upd : '0;
            m_rn = m_ctrl[2] ? rn_upd : '0;
            m_prev_fu = fu;
            m_rc_sync = m_rc_ff;
            m_rc_ff = ramp_clock;
            if (m_edges < 32) begin
                m_edges++;
            end
            if (wr_en) begin
                case (addr)
                    4'd0: m_ctrl = wdata[4:0];
                    4'd1: begin
                        m_kp = wdata[3:0];
                        m_ki = wdata[7:4];
                        m_kr = wdata[11:8];
                    end
                    4'd2: m_offset = wdata[Nadc+1:0];
                    4'd3: m_ext = wdata[Npi-1:0];
                    default: ;
                endcase
            end
        end
    end

    task automatic compare_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_outputs();
        for (int k = 0; k < Nout; k++) begin
            compare_val($sformatf("pi_ctl_o[%0d]", k), 32'(pi_model()), 32'(pi_ctl[k]));
        end
        compare_val("freq_lvl_cross_o", 32'(m_lvl), 32'(freq_lvl_cross));
        compare_val("wait_on_reset_b_o", 32'(m_edges >= 32), 32'(wait_on_reset_b));
    endtask

    // outputs are checked at each falling edge before the inputs change
    task automatic tick(input int n);
        repeat (n) begin
            @(negedge clk);
            check_outputs();
        end
    endtask

    task automatic cfg_write(input cfg_addr_t a, input cfg_data_t d);
        wr_en = 1'b1;
        addr = a;
        wdata = d;
        tick(1);
        wr_en = 1'b0;
    endtask

    task automatic read_word(input cfg_addr_t a, input cfg_data_t exp, output cfg_data_t got);
        addr = a;
        #1;
        got = rdata;
        compare_val($sformatf("rdata_o at address %0d", a), 32'(exp), 32'(got));
        tick(1);
    endtask

    task automatic random_word();
        for (int k = 0; k < Nti; k++) begin
            din[k] = adc_sample_t'($urandom);
        end
    endtask

    task automatic const_word(input int s0, input int s1, input int s2, input int s3);
        din[0] = adc_sample_t'(s0);
        din[1] = adc_sample_t'(s1);
        din[2] = adc_sample_t'(s2);
        din[3] = adc_sample_t'(s3);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-14s %s", name, (err_count == errs_before) ? "ok" : "had errors");
    endtask

    task automatic test_reset_wait();
        int errs_before;
        errs_before = err_count;
        repeat (reset_cycles) begin
            tick(1);
            compare_val("wait_on_reset_b_o", 32'd0, 32'(wait_on_reset_b));
        end
        ext_rstb = 1'b1;
        for (int n = 1; n <= wait_cycles; n++) begin
            random_word();
            tick(1);
            compare_val("wait_on_reset_b_o", 32'(n >= 32), 32'(wait_on_reset_b));
            if (n < 32) begin
                compare_val("pi_ctl_o[0]", 32'd0, 32'(pi_ctl[0]));
            end
        end
        report_test("reset wait", errs_before);
    endtask

    // large offset drives the detector into saturation often
    task automatic test_proportional();
        int errs_before;
        errs_before = err_count;
        cfg_write(4'd1, 16'h0004);
        cfg_write(4'd2, 16'd300);
        cfg_write(4'd0, 16'h0000);
        repeat (prop_cycles) begin
            random_word();
            tick(1);
        end
        cfg_write(4'd0, 16'h0001);
        repeat (prop_cycles) begin
            random_word();
            tick(1);
        end
        report_test("proportional", errs_before);
    endtask

    // a step in the constant error makes the frequency update grow once
    task automatic test_integral();
        int errs_before;
        errs_before = err_count;
        cfg_write(4'd2, 16'h0000);
        cfg_write(4'd1, 16'h0032);
        const_word(10, 20, 30, 40);
        cfg_write(4'd0, 16'h0002);
        tick(freq_cycles);
        const_word(10, 30, 50, 70);
        tick(freq_cycles);
        report_test("integral", errs_before);
    endtask

    task automatic test_ramp();
        int errs_before;
        errs_before = err_count;
        cfg_write(4'd1, 16'h0212);
        cfg_write(4'd0, 16'h0006);
        for (int i = 0; i < ramp_cycles; i++) begin
            if (i % 20 == 0) begin
                ramp_clock = ~ramp_clock;
            end
            random_word();
            tick(1);
        end
        cfg_write(4'd0, 16'h0002);
        repeat (20) begin
            random_word();
            tick(1);
        end
        ramp_clock = 1'b0;
        report_test("ramp", errs_before);
    endtask

    task automatic test_override();
        int errs_before;
        errs_before = err_count;
        cfg_write(4'd3, 16'h005a);
        cfg_write(4'd0, 16'h000a);
        repeat (ovr_cycles) begin
            random_word();
            tick(1);
            for (int k = 0; k < Nout; k++) begin
                compare_val($sformatf("pi_ctl_o[%0d]", k), 32'h5a, 32'(pi_ctl[k]));
            end
        end
        cfg_write(4'd0, 16'h0002);
        repeat (ovr_cycles) begin
            random_word();
            tick(1);
        end
        report_test("override", errs_before);
    endtask

    task automatic test_snapshot();
        int        errs_before;
        cfg_data_t first_read [5];
        cfg_data_t got;
        errs_before = err_count;
        random_word();
        cfg_write(4'd0, 16'h0002);
        tick(2);
        cfg_write(4'd0, 16'h0012);
        tick(3);
        for (int a = 4; a <= 8; a++) begin
            read_word(cfg_addr_t'(a), snap_word(cfg_addr_t'(a)), first_read[a-4]);
        end
        // snapshot must not move while the request is held
        tick(10);
        for (int a = 4; a <= 8; a++) begin
            read_word(cfg_addr_t'(a), first_read[a-4], got);
        end
        for (int a = 9; a < 16; a++) begin
            read_word(cfg_addr_t'(a), 16'h0000, got);
        end
        // writable registers read back what was written
        read_word(4'd0, cfg_data_t'(m_ctrl), got);
        read_word(4'd1, cfg_data_t'({m_kr, m_ki, m_kp}), got);
        read_word(4'd2, cfg_data_t'(int'(m_offset)), got);
        read_word(4'd3, cfg_data_t'(m_ext), got);
        report_test("snapshot", errs_before);
    endtask

    initial begin
        seed_val = $urandom(32'h29ae_1b19);
        err_count = 0;
        pass_count = 0;
        cycle_count = 0;
        clk = 1'b0;
        ext_rstb = 1'b0;
        ramp_clock = 1'b0;
        wr_en = 1'b0;
        addr = '0;
        wdata = '0;
        for (int k = 0; k < Nti; k++) begin
            din[k] = '0;
        end
        test_reset_wait();
        test_proportional();
        test_integral();
        test_ramp();
        test_override();
        test_snapshot();
        $display("checks passed %0d, checks failed %0d", pass_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the CDR testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -f vlog.f --top-module tb_cdr_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_cdr_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^>>> PASS$'; then
    exit 0
fi
exit 1

// ==== verilog/cdr_cfg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module cdr_cfg_regs #(
    parameter int gain_width      = 4,
    parameter int phase_est_shift = 12
) (
    input  wire logic                 clk,
    input  wire logic                 ext_rstb,
    input  wire logic                 wr_en_i,
    input  wire cdr_pack::cfg_addr_t  addr_i,
    input  wire cdr_pack::cfg_data_t  wdata_i,
    output cdr_pack::cfg_data_t       rdata_o,
    output logic                      invert_o,
    output logic                      en_freq_est_o,
    output logic                      en_ramp_est_o,
    output logic                      en_ext_pi_ctl_o,
    output logic                      sample_req_o,
    output logic [gain_width-1:0]     kp_o,
    output logic [gain_width-1:0]     ki_o,
    output logic [gain_width-1:0]     kr_o,
    output cdr_pack::pd_err_t         pd_offset_o,
    output cdr_pack::pi_code_t        ext_pi_ctl_o,
    input  wire cdr_pack::pd_err_t    snap_phase_i,
    input  wire logic signed [cdr_pack::Nadc+1+phase_est_shift:0] snap_freq_i,
    input  wire logic signed [cdr_pack::Nadc+1+phase_est_shift:0] snap_ramp_i
);
    import cdr_pack::*;

    localparam int acc_w  = Nadc + 2 + phase_est_shift;
    localparam int wide_w = 2 * Ncfg_data;

    // register map
    localparam cfg_addr_t addr_ctrl      = cfg_addr_t'(0);
    localparam cfg_addr_t addr_gains     = cfg_addr_t'(1);
    localparam cfg_addr_t addr_offset    = cfg_addr_t'(2);
    localparam cfg_addr_t addr_ext_pi    = cfg_addr_t'(3);
    localparam cfg_addr_t addr_snap_ph   = cfg_addr_t'(4);
    localparam cfg_addr_t addr_snap_fr_l = cfg_addr_t'(5);
    localparam cfg_addr_t addr_snap_fr_h = cfg_addr_t'(6);
    localparam cfg_addr_t addr_snap_rp_l = cfg_addr_t'(7);
    localparam cfg_addr_t addr_snap_rp_h = cfg_addr_t'(8);

    logic [4:0]        ctrl_q;
    logic [wide_w-1:0] freq_wide;
    logic [wide_w-1:0] ramp_wide;

    assign invert_o        = ctrl_q[0];
    assign en_freq_est_o   = ctrl_q[1];
    assign en_ramp_est_o   = ctrl_q[2];
    assign en_ext_pi_ctl_o = ctrl_q[3];
    assign sample_req_o    = ctrl_q[4];

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            ctrl_q       <= '0;
            kp_o         <= '0;
            ki_o         <= '0;
            kr_o         <= '0;
            pd_offset_o  <= '0;
            ext_pi_ctl_o <= '0;
        end else if (wr_en_i) begin
            case (addr_i)
                addr_ctrl: ctrl_q <= wdata_i[4:0];
                addr_gains: begin
                    kp_o <= wdata_i[gain_width-1:0];
                    ki_o <= wdata_i[2*gain_width-1:gain_width];
                    kr_o <= wdata_i[3*gain_width-1:2*gain_width];
                end
                addr_offset: pd_offset_o <= wdata_i[Nadc+1:0];
                addr_ext_pi: ext_pi_ctl_o <= wdata_i[Npi-1:0];
                default: ;
            endcase
        end
    end

    // wide snapshots are sign-extended, then read as two halves
    assign freq_wide = {{(wide_w-acc_w){snap_freq_i[acc_w-1]}}, snap_freq_i};
    assign ramp_wide = {{(wide_w-acc_w){snap_ramp_i[acc_w-1]}}, snap_ramp_i};

    always_comb begin
        case (addr_i)
            addr_ctrl:      rdata_o = {{(Ncfg_data-5){1'b0}}, ctrl_q};
            addr_gains:     rdata_o = {{(Ncfg_data-3*gain_width){1'b0}}, kr_o, ki_o, kp_o};
            addr_offset:    rdata_o = {{(Ncfg_data-Nadc-2){pd_offset_o[Nadc+1]}}, pd_offset_o};
            addr_ext_pi:    rdata_o = {{(Ncfg_data-Npi){1'b0}}, ext_pi_ctl_o};
            addr_snap_ph:   rdata_o = {{(Ncfg_data-Nadc-2){snap_phase_i[Nadc+1]}}, snap_phase_i};
            addr_snap_fr_l: rdata_o = freq_wide[Ncfg_data-1:0];
            addr_snap_fr_h: rdata_o = freq_wide[wide_w-1:Ncfg_data];
            addr_snap_rp_l: rdata_o = ramp_wide[Ncfg_data-1:0];
            addr_snap_rp_h: rdata_o = ramp_wide[wide_w-1:Ncfg_data];
            default:        rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/cdr_pack.sv ====
`default_nettype none

package cdr_pack;

    // adc sample width in bits
    localparam int Nadc = 8;

    // interleaved lanes delivered per clock
    localparam int Nti = 4;

    // phase interpolator code width and number of interpolators driven
    localparam int Npi  = 8;
    localparam int Nout = 2;

    // configuration port sizes
    localparam int Ncfg_addr = 4;
    localparam int Ncfg_data = 16;

    // one signed adc sample
    typedef logic signed [Nadc-1:0] adc_sample_t;

    // saturated phase error, two bits of headroom over a sample
    typedef logic signed [Nadc+1:0] pd_err_t;

    // code sent to a phase interpolator
    typedef logic [Npi-1:0] pi_code_t;

    // configuration address and data words
    typedef logic [Ncfg_addr-1:0] cfg_addr_t;
    typedef logic [Ncfg_data-1:0] cfg_data_t;

endpackage

`default_nettype wire

// ==== verilog/cdr_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cdr_top #(
    parameter int gain_width      = 4,
    parameter int phase_est_shift = 12
) (
    input  wire logic                  clk,
    input  wire logic                  ext_rstb,
    input  wire cdr_pack::adc_sample_t din_i [cdr_pack::Nti-1:0],
    input  wire logic                  ramp_clock_i,
    input  wire logic                  wr_en_i,
    input  wire cdr_pack::cfg_addr_t   addr_i,
    input  wire cdr_pack::cfg_data_t   wdata_i,
    output cdr_pack::cfg_data_t        rdata_o,
    output cdr_pack::pi_code_t         pi_ctl_o [cdr_pack::Nout-1:0],
    output logic                       freq_lvl_cross_o,
    output logic                       wait_on_reset_b_o
);
    import cdr_pack::*;

    pd_err_t   pd_err;
    pd_err_t   pd_offset;
    pi_code_t  ext_pi_ctl;
    pd_err_t   snap_phase;
    logic      invert;
    logic      en_freq_est;
    logic      en_ramp_est;
    logic      en_ext_pi_ctl;
    logic      sample_req;
    logic [gain_width-1:0] kp;
    logic [gain_width-1:0] ki;
    logic [gain_width-1:0] kr;
    logic signed [Nadc+1+phase_est_shift:0] snap_freq;
    logic signed [Nadc+1+phase_est_shift:0] snap_ramp;

    mm_pd u_mm_pd (
        .din_i       (din_i),
        .pd_offset_i (pd_offset),
        .pd_out_o    (pd_err)
    );

    cdr_cfg_regs #(
        .gain_width      (gain_width),
        .phase_est_shift (phase_est_shift)
    ) u_cfg_regs (
        .clk             (clk),
        .ext_rstb        (ext_rstb),
        .wr_en_i         (wr_en_i),
        .addr_i          (addr_i),
        .wdata_i         (wdata_i),
        .rdata_o         (rdata_o),
        .invert_o        (invert),
        .en_freq_est_o   (en_freq_est),
        .en_ramp_est_o   (en_ramp_est),
        .en_ext_pi_ctl_o (en_ext_pi_ctl),
        .sample_req_o    (sample_req),
        .kp_o            (kp),
        .ki_o            (ki),
        .kr_o            (kr),
        .pd_offset_o     (pd_offset),
        .ext_pi_ctl_o    (ext_pi_ctl),
        .snap_phase_i    (snap_phase),
        .snap_freq_i     (snap_freq),
        .snap_ramp_i     (snap_ramp)
    );

    mm_cdr #(
        .gain_width      (gain_width),
        .phase_est_shift (phase_est_shift)
    ) u_mm_cdr (
        .clk               (clk),
        .ext_rstb          (ext_rstb),
        .pd_err_i          (pd_err),
        .ramp_clock_i      (ramp_clock_i),
        .invert_i          (invert),
        .en_freq_est_i     (en_freq_est),
        .en_ramp_est_i     (en_ramp_est),
        .en_ext_pi_ctl_i   (en_ext_pi_ctl),
        .sample_req_i      (sample_req),
        .kp_i              (kp),
        .ki_i              (ki),
        .kr_i              (kr),
        .ext_pi_ctl_i      (ext_pi_ctl),
        .pi_ctl_o          (pi_ctl_o),
        .freq_lvl_cross_o  (freq_lvl_cross_o),
        .wait_on_reset_b_o (wait_on_reset_b_o),
        .snap_phase_o      (snap_phase),
        .snap_freq_o       (snap_freq),
        .snap_ramp_o       (snap_ramp)
    );

endmodule

`default_nettype wire

// ==== verilog/mm_cdr.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_cdr #(
    parameter int gain_width      = 4,
    parameter int phase_est_shift = 12
) (
    input  wire logic                 clk,
    input  wire logic                 ext_rstb,
    input  wire cdr_pack::pd_err_t    pd_err_i,
    input  wire logic                 ramp_clock_i,
    input  wire logic                 invert_i,
    input  wire logic                 en_freq_est_i,
    input  wire logic                 en_ramp_est_i,
    input  wire logic                 en_ext_pi_ctl_i,
    input  wire logic                 sample_req_i,
    input  wire logic [gain_width-1:0] kp_i,
    input  wire logic [gain_width-1:0] ki_i,
    input  wire logic [gain_width-1:0] kr_i,
    input  wire cdr_pack::pi_code_t   ext_pi_ctl_i,
    output cdr_pack::pi_code_t        pi_ctl_o [cdr_pack::Nout-1:0],
    output logic                      freq_lvl_cross_o,
    output logic                      wait_on_reset_b_o,
    output cdr_pack::pd_err_t         snap_phase_o,
    output logic signed [cdr_pack::Nadc+1+phase_est_shift:0] snap_freq_o,
    output logic signed [cdr_pack::Nadc+1+phase_est_shift:0] snap_ramp_o
);
    import cdr_pack::*;

    localparam int acc_w = Nadc + 2 + phase_est_shift;

    typedef logic signed [acc_w-1:0] acc_t;
    typedef logic signed [acc_w:0]   diff_t;
    typedef enum logic [1:0] {WAIT, READY, SAMPLE} sampler_state_t;

    sampler_state_t sampler_state;

    logic [4:0] wait_cnt;
    logic       ramp_clock_ff;
    logic       ramp_clock_sync;

    pd_err_t err_inv;
    pd_err_t err_eff;
    acc_t    err_wide;

    acc_t ramp_pls_q;
    acc_t ramp_pls_upd;
    acc_t ramp_pls_d;
    acc_t ramp_neg_q;
    acc_t ramp_neg_upd;
    acc_t ramp_neg_d;
    acc_t freq_q;
    acc_t freq_upd;
    acc_t freq_d;
    acc_t prev_freq_upd_q;
    acc_t phase_q;
    acc_t phase_d;
    acc_t phase_shifted;

    diff_t    freq_diff;
    pd_err_t  phase_out;
    pi_code_t loop_pi_code;

    // hold the loop quiet for 32 cycles after each reset
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            wait_cnt          <= '0;
            wait_on_reset_b_o <= 1'b0;
        end else begin
            if (wait_cnt != 5'd31) begin
                wait_cnt <= wait_cnt + 5'd1;
            end
            wait_on_reset_b_o <= (wait_cnt == 5'd31);
        end
    end

    always_comb begin
        err_inv  = invert_i ? -pd_err_i : pd_err_i;
        err_eff  = wait_on_reset_b_o ? err_inv : '0;
        err_wide = acc_t'(err_eff);

        // separate ramp integrators for the high and low halves of the ramp
        ramp_pls_upd = ramp_clock_i ? ramp_pls_q + (err_wide << kr_i) : ramp_pls_q;
        ramp_neg_upd = ramp_clock_i ? ramp_neg_q : ramp_neg_q + (err_wide << kr_i);
        ramp_pls_d   = en_ramp_est_i ? ramp_pls_upd : '0;
        ramp_neg_d   = en_ramp_est_i ? ramp_neg_upd : '0;

        freq_upd  = (err_wide << ki_i) + (ramp_clock_sync ? ramp_pls_q : -ramp_neg_q);
        freq_d    = en_freq_est_i ? freq_q + freq_upd : freq_q;
        freq_diff = diff_t'(freq_upd) - diff_t'(prev_freq_upd_q);

        phase_d = phase_q + (err_wide << kp_i) + freq_q;

        // integer part of the phase estimate
        phase_shifted = phase_q >>> phase_est_shift;
        phase_out     = phase_shifted[Nadc+1:0];
        loop_pi_code  = phase_out[Npi-1:0];
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_q         <= '0;
            freq_q          <= '0;
            prev_freq_upd_q <= '0;
            ramp_pls_q      <= '0;
            ramp_neg_q      <= '0;
            ramp_clock_ff   <= 1'b0;
            ramp_clock_sync <= 1'b0;
        end else begin
            phase_q         <= wait_on_reset_b_o ? phase_d : '0;
            freq_q          <= wait_on_reset_b_o ? freq_d : '0;
            prev_freq_upd_q <= wait_on_reset_b_o ? freq_upd : '0;
            ramp_pls_q      <= wait_on_reset_b_o ? ramp_pls_d : '0;
            ramp_neg_q      <= wait_on_reset_b_o ? ramp_neg_d : '0;
            // ramp_clock_i comes from another domain
            ramp_clock_ff   <= ramp_clock_i;
            ramp_clock_sync <= ramp_clock_ff;
        end
    end

    always_comb begin
        for (int k = 0; k < Nout; k++) begin
            pi_ctl_o[k] = en_ext_pi_ctl_i ? ext_pi_ctl_i : loop_pi_code;
        end
    end

    // set when the frequency update grew since the previous cycle
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            freq_lvl_cross_o <= 1'b0;
        end else begin
            freq_lvl_cross_o <= !freq_diff[acc_w] && (freq_diff != '0);
        end
    end

    // one snapshot per low-to-high request, a held request does nothing more
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            sampler_state <= WAIT;
            snap_phase_o  <= '0;
            snap_freq_o   <= '0;
            snap_ramp_o   <= '0;
        end else begin
            case (sampler_state)
                WAIT: sampler_state <= sample_req_i ? WAIT : READY;
                READY: sampler_state <= sample_req_i ? SAMPLE : READY;
                SAMPLE: begin
                    snap_phase_o  <= phase_out;
                    snap_freq_o   <= freq_upd;
                    snap_ramp_o   <= ramp_clock_i ? ramp_pls_upd : ramp_neg_upd;
                    sampler_state <= WAIT;
                end
                default: sampler_state <= WAIT;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mm_pd.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_pd (
    input  wire cdr_pack::adc_sample_t din_i [cdr_pack::Nti-1:0],
    input  wire cdr_pack::pd_err_t     pd_offset_i,
    output cdr_pack::pd_err_t          pd_out_o
);
    import cdr_pack::*;

    // wide enough for Nti-1 terms plus the offset without overflow
    localparam int sum_w = Nadc + 3 + $clog2(Nti);

    typedef logic signed [sum_w-1:0] sum_t;

    // clamp limits of the pd_err_t range
    localparam sum_t pd_max = sum_t'(2 ** (Nadc + 1) - 1);
    localparam sum_t pd_min = -pd_max - sum_t'(1);

    sum_t cur_s;
    sum_t prev_s;
    sum_t acc;

    always_comb begin
        acc = sum_t'(pd_offset_i);
        cur_s = '0;
        prev_s = '0;
        for (int k = 1; k < Nti; k++) begin
            cur_s = sum_t'(din_i[k]);
            prev_s = sum_t'(din_i[k-1]);
            // sgn(din[k-1]) * din[k]
            acc = din_i[k-1][Nadc-1] ? acc - cur_s : acc + cur_s;
            // minus sgn(din[k]) * din[k-1]
            acc = din_i[k][Nadc-1] ? acc + prev_s : acc - prev_s;
        end

        if (acc > pd_max) begin
            pd_out_o = pd_max[Nadc+1:0];
        end else if (acc < pd_min) begin
            pd_out_o = pd_min[Nadc+1:0];
        end else begin
            pd_out_o = acc[Nadc+1:0];
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/cdr_pack.sv
verilog/mm_pd.sv
verilog/cdr_cfg_regs.sv
verilog/mm_cdr.sv
verilog/cdr_top.sv
bench/tb_cdr_top.sv
